/* tb/predict_testdata.txt */
# R name pc rvc taken target call ret
# F name mode(S start, R redirect, C continue) pc stall taken slot call ret next_pc
# S name
# cold btb, sequential block addresses
F cold_miss          S 00001000 0 0 0 0 0 00001008
F cold_chain         C 00001008 0 0 0 0 0 00001010
F cold_mid_block     S 00001006 0 0 0 0 0 00001008
# one taken resolve moves the counter to 2
R train_taken          00002000 1 1 00003000 0 0
F train_hit          S 00002000 0 1 0 0 0 00003000
F train_follow       C 00003000 0 0 0 0 0 00003008
R train_not_taken      00002000 1 0 00003000 0 0
F train_fall_back    S 00002000 0 0 0 0 0 00002008
# slot placement from the branch end address
R slot_full_at_2       00004002 0 1 00005000 1 0
F slot_full_hit      S 00004000 0 1 2 1 0 00005000
R slot_rvc_at_2        00004042 1 1 00005100 0 1
F slot_rvc_hit       S 00004040 0 1 1 0 1 00005100
F slot_masked        S 00004044 0 0 0 0 0 00004048
F slot_same_offset   S 00004004 0 1 2 1 0 00005000
R slot_upper           00004006 1 1 00005200 0 1
F slot_lower_wins    S 00004000 0 1 2 1 0 00005000
F slot_upper_alone   S 00004006 0 1 3 0 1 00005200
# same index, other tag
F tag_mismatch       S 00006000 0 0 0 0 0 00006008
F tag_mismatch_rvc   S 00006040 0 0 0 0 0 00006048
# chained fetches, stall, redirect and stop
F chain_start        S 00004000 0 1 2 1 0 00005000
F chain_target       C 00005000 0 0 0 0 0 00005008
F chain_seq          C 00005008 0 0 0 0 0 00005010
F stall_start        S 00004040 3 1 1 0 1 00005100
F stall_chain        C 00005100 2 0 0 0 0 00005108
F redirect_mid       R 00004042 0 1 1 0 1 00005100
F redirect_chain     C 00005100 1 0 0 0 0 00005108
S stop_idle
F restart            S 00001000 0 0 0 0 0 00001008
# counter saturates at 3, then two not-taken steps
R sat_up_1             00004042 1 1 00005100 0 1
R sat_up_2             00004042 1 1 00005100 0 1
R sat_down_1           00004042 1 0 00005100 0 1
F sat_still_taken    S 00004040 0 1 1 0 1 00005100
R sat_down_2           00004042 1 0 00005100 0 1
F sat_fall_back      S 00004040 0 0 0 0 0 00004048

/* vlog.f */
src/predict_pkg.sv
src/data_array_2p.sv
src/btb.sv
src/bim_counter_table.sv
src/fetch_pc_ctrl.sv
src/predict_top.sv
tb/tb_predict_top.sv

/* Makefile */
SIM      = verilator
VFLAGS   = --binary --timing -Wno-fatal
TOP      = tb_predict_top
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^TEST PASSED$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_predict_top.sv */
// predict_top testbench driven by operations and expected fetch results from a data file
`timescale 1ns/1ns

module tb_predict_top
  import predict_pkg::*;
();

  localparam int    RESET_CYCLES    = 10;
  localparam int    CYCLES_PER_LINE = 30;
  localparam int    STOP_WATCH      = 6;
  localparam string DATA_FILE       = "tb/predict_testdata.txt";

  logic                       i_clk;
  logic                       i_reset_n;
  logic                       i_start;
  logic [VADDR_W-1:0]         i_start_pc;
  logic                       i_stop;
  logic                       i_stall;
  logic                       i_redirect_valid;
  logic [VADDR_W-1:0]         i_redirect_pc;
  logic                       i_res_valid;
  logic [VADDR_W-1:0]         i_res_pc;
  logic                       i_res_is_rvc;
  logic                       i_res_taken;
  logic [VADDR_W-1:0]         i_res_target;
  logic                       i_res_is_call;
  logic                       i_res_is_ret;
  logic                       o_fetch_valid;
  logic [VADDR_W-1:0]         o_fetch_pc;
  logic                       o_pred_taken;
  logic [SLOT_MSB-SLOT_LSB:0] o_pred_slot;
  logic                       o_pred_is_call;
  logic                       o_pred_is_ret;
  logic [VADDR_W-1:0]         o_next_pc;

  string lines[$];
  int    n_pass;
  int    n_fail;
  int    cycle_cnt;
  int    cycle_limit;
  bit    file_ok;

  predict_top #(
    .ENTRIES (BTB_ENTRY_SIZE)
  ) predict_top_i (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_start          (i_start),
    .i_start_pc       (i_start_pc),
    .i_stop           (i_stop),
    .i_stall          (i_stall),
    .i_redirect_valid (i_redirect_valid),
    .i_redirect_pc    (i_redirect_pc),
    .i_res_valid      (i_res_valid),
    .i_res_pc         (i_res_pc),
    .i_res_is_rvc     (i_res_is_rvc),
    .i_res_taken      (i_res_taken),
    .i_res_target     (i_res_target),
    .i_res_is_call    (i_res_is_call),
    .i_res_is_ret     (i_res_is_ret),
    .o_fetch_valid    (o_fetch_valid),
    .o_fetch_pc       (o_fetch_pc),
    .o_pred_taken     (o_pred_taken),
    .o_pred_slot      (o_pred_slot),
    .o_pred_is_call   (o_pred_is_call),
    .o_pred_is_ret    (o_pred_is_ret),
    .o_next_pc        (o_next_pc)
  );

  always #5 i_clk = ~i_clk;

  // limit is known once the data file has been read
  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("fetch never completed, run stopped after %0d cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  // outputs are sampled right after the falling edge and before new drives
  task automatic next_cycle();
    @(negedge i_clk);
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      n_pass++;
      $display("pass  %s", name);
    end else begin
      n_fail++;
      $display("fail  %s (%0d mismatches)", name, errs);
    end
  endtask

  task automatic load_file();
    int                 fd;
    int                 n;
    int                 stall;
    int                 total_stall;
    string              line;
    string              kind;
    string              name;
    string              mode;
    logic [VADDR_W-1:0] pc;
    total_stall = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("cannot open data file %s", DATA_FILE);
      file_ok = 1'b0;
    end else begin
      file_ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%s", kind);
        // skip blank and comment lines
        if (n == 1 && kind.substr(0, 0) != "#") begin
          lines.push_back(line);
          if (kind == "F") begin
            n = $sscanf(line, "%s %s %s %h %d", kind, name, mode, pc, stall);
            if (n == 5) begin
              total_stall += stall;
            end
          end
        end
      end
      $fclose(fd);
      cycle_limit = CYCLES_PER_LINE * lines.size() + RESET_CYCLES + total_stall;
    end
  endtask

  // ----------------------------------------------------------------------
  // operations
  // ----------------------------------------------------------------------
  task automatic pulse_resolve(
    input logic [VADDR_W-1:0] pc,
    input logic               rvc,
    input logic               taken,
    input logic [VADDR_W-1:0] target,
    input logic               call,
    input logic               ret
  );
    next_cycle();
    i_res_valid   = 1'b1;
    i_res_pc      = pc;
    i_res_is_rvc  = rvc;
    i_res_taken   = taken;
    i_res_target  = target;
    i_res_is_call = call;
    i_res_is_ret  = ret;
    next_cycle();
    i_res_valid   = 1'b0;
  endtask

  task automatic run_fetch(
    input string              name,
    input string              mode,
    input logic [VADDR_W-1:0] pc,
    input int                 stall,
    input logic               e_taken,
    input logic [1:0]         e_slot,
    input logic               e_call,
    input logic               e_ret,
    input logic [VADDR_W-1:0] e_next
  );
    int   errs;
    int   waited;
    int   stall_left;
    logic seen;
    errs       = 0;
    stall_left = stall;
    // S starts, R redirects, C takes the next fetch of the running chain
    if (mode == "S" || mode == "R") begin
      next_cycle();
      i_start          = (mode == "S");
      i_redirect_valid = (mode == "R");
      i_start_pc       = (mode == "S") ? pc : ~pc;
      i_redirect_pc    = (mode == "R") ? pc : ~pc;
    end else if (mode != "C") begin
      $display("unknown fetch mode %s in test %s", mode, name);
      errs++;
    end
    if (errs == 0) begin
      next_cycle();
      seen             = o_fetch_valid;
      waited           = 1;
      i_start          = 1'b0;
      i_redirect_valid = 1'b0;
      while (!seen) begin
        i_stall = (stall_left > 0);
        if (stall_left > 0) begin
          stall_left--;
        end
        next_cycle();
        waited++;
        seen = o_fetch_valid;
      end
      // result is due two cycles after the pulse plus the stall
      if (waited != stall + 2) begin
        $display("CHECK FAILED %s: latency expected %0d actual %0d", name, stall + 2, waited);
        errs++;
      end
      if (o_fetch_pc !== pc) begin
        $display("CHECK FAILED %s: o_fetch_pc expected %h actual %h", name, pc, o_fetch_pc);
        errs++;
      end
      if (o_pred_taken !== e_taken) begin
        $display("CHECK FAILED %s: o_pred_taken expected %b actual %b",
                 name, e_taken, o_pred_taken);
        errs++;
      end
      if (e_taken && o_pred_slot !== e_slot) begin
        $display("CHECK FAILED %s: o_pred_slot expected %0d actual %0d",
                 name, e_slot, o_pred_slot);
        errs++;
      end
      if (o_pred_is_call !== e_call) begin
        $display("CHECK FAILED %s: o_pred_is_call expected %b actual %b",
                 name, e_call, o_pred_is_call);
        errs++;
      end
      if (o_pred_is_ret !== e_ret) begin
        $display("CHECK FAILED %s: o_pred_is_ret expected %b actual %b",
                 name, e_ret, o_pred_is_ret);
        errs++;
      end
      if (o_next_pc !== e_next) begin
        $display("CHECK FAILED %s: o_next_pc expected %h actual %h", name, e_next, o_next_pc);
        errs++;
      end
      i_stall = 1'b0;
    end
    report_test(name, errs);
  endtask

  task automatic run_stop(input string name);
    int errs;
    errs = 0;
    next_cycle();
    i_stop = 1'b1;
    next_cycle();
    i_stop = 1'b0;
    repeat (STOP_WATCH) begin
      next_cycle();
      if (o_fetch_valid !== 1'b0 && errs == 0) begin
        $display("CHECK FAILED %s: o_fetch_valid expected 0 actual %b", name, o_fetch_valid);
        errs++;
      end
    end
    report_test(name, errs);
  endtask

  task automatic run_line(input string line);
    int                 n;
    int                 stall;
    string              kind;
    string              name;
    string              mode;
    logic [VADDR_W-1:0] pc;
    logic [VADDR_W-1:0] addr;
    logic               f_a;
    logic               f_b;
    logic               f_c;
    logic               f_d;
    logic [1:0]         slot;
    n = $sscanf(line, "%s %s", kind, name);
    if (kind == "R") begin
      n = $sscanf(line, "%s %s %h %d %d %h %d %d", kind, name, pc, f_a, f_b, addr, f_c, f_d);
      if (n == 8) begin
        pulse_resolve(pc, f_a, f_b, addr, f_c, f_d);
      end else begin
        $display("malformed resolve line in data file: %s", line);
        n_fail++;
      end
    end else if (kind == "F") begin
      n = $sscanf(line, "%s %s %s %h %d %d %d %d %d %h",
                  kind, name, mode, pc, stall, f_a, slot, f_c, f_d, addr);
      if (n == 10) begin
        run_fetch(name, mode, pc, stall, f_a, slot, f_c, f_d, addr);
      end else begin
        $display("malformed fetch line in data file: %s", line);
        n_fail++;
      end
    end else if (kind == "S" && n == 2) begin
      run_stop(name);
    end else begin
      $display("unknown line in data file: %s", line);
      n_fail++;
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    i_clk            = 1'b0;
    i_reset_n        = 1'b0;
    i_start          = 1'b0;
    i_start_pc       = '0;
    i_stop           = 1'b0;
    i_stall          = 1'b0;
    i_redirect_valid = 1'b0;
    i_redirect_pc    = '0;
    i_res_valid      = 1'b0;
    i_res_pc         = '0;
    i_res_is_rvc     = 1'b0;
    i_res_taken      = 1'b0;
    i_res_target     = '0;
    i_res_is_call    = 1'b0;
    i_res_is_ret     = 1'b0;
    n_pass           = 0;
    n_fail           = 0;
    cycle_cnt        = 0;
    cycle_limit      = 0;
    load_file();
    repeat (RESET_CYCLES) @(negedge i_clk);
    i_reset_n = 1'b1;
    if (!file_ok) begin
      n_fail++;
    end else begin
      foreach (lines[i]) begin
        run_line(lines[i]);
      end
    end
    $display("tests done, %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0 && n_pass > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* src/predict_top.sv */
// branch predictor top, fetch fsm with btb and bimodal counter tables
`timescale 1ns/1ns

module predict_top
  import predict_pkg::*;
#(
  parameter int ENTRIES = BTB_ENTRY_SIZE
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,

  input  logic                       i_start,
  input  logic [VADDR_W-1:0]         i_start_pc,
  input  logic                       i_stop,
  input  logic                       i_stall,
  input  logic                       i_redirect_valid,
  input  logic [VADDR_W-1:0]         i_redirect_pc,

  // resolve from the back end
  input  logic                       i_res_valid,
  input  logic [VADDR_W-1:0]         i_res_pc,
  input  logic                       i_res_is_rvc,
  input  logic                       i_res_taken,
  input  logic [VADDR_W-1:0]         i_res_target,
  input  logic                       i_res_is_call,
  input  logic                       i_res_is_ret,

  output logic                       o_fetch_valid,
  output logic [VADDR_W-1:0]         o_fetch_pc,
  output logic                       o_pred_taken,
  output logic [SLOT_MSB-SLOT_LSB:0] o_pred_slot,
  output logic                       o_pred_is_call,
  output logic                       o_pred_is_ret,
  output logic [VADDR_W-1:0]         o_next_pc
);

  logic                           w_s0_valid;
  logic [VADDR_W-1:0]             w_s0_pc;
  logic [SLOT_N-1:0]              w_s1_hit;
  logic [SLOT_N-1:0]              w_s1_taken;
  logic [SLOT_N-1:0][VADDR_W-1:0] w_s1_target;
  logic [SLOT_N-1:0]              w_s1_is_call;
  logic [SLOT_N-1:0]              w_s1_is_ret;

  fetch_pc_ctrl u_fetch_pc_ctrl (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_start          (i_start),
    .i_start_pc       (i_start_pc),
    .i_stop           (i_stop),
    .i_stall          (i_stall),
    .i_redirect_valid (i_redirect_valid),
    .i_redirect_pc    (i_redirect_pc),
    .i_s1_hit         (w_s1_hit),
    .i_s1_taken       (w_s1_taken),
    .i_s1_target      (w_s1_target),
    .i_s1_is_call     (w_s1_is_call),
    .i_s1_is_ret      (w_s1_is_ret),
    .o_s0_valid       (w_s0_valid),
    .o_s0_pc          (w_s0_pc),
    .o_fetch_valid    (o_fetch_valid),
    .o_fetch_pc       (o_fetch_pc),
    .o_pred_taken     (o_pred_taken),
    .o_pred_slot      (o_pred_slot),
    .o_pred_is_call   (o_pred_is_call),
    .o_pred_is_ret    (o_pred_is_ret),
    .o_next_pc        (o_next_pc)
  );

  btb #(
    .ENTRIES (ENTRIES)
  ) u_btb (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_s0_valid    (w_s0_valid),
    .i_s0_pc       (w_s0_pc),
    .i_res_valid   (i_res_valid),
    .i_res_pc      (i_res_pc),
    .i_res_is_rvc  (i_res_is_rvc),
    .i_res_taken   (i_res_taken),
    .i_res_target  (i_res_target),
    .i_res_is_call (i_res_is_call),
    .i_res_is_ret  (i_res_is_ret),
    .o_s1_hit      (w_s1_hit),
    .o_s1_target   (w_s1_target),
    .o_s1_is_call  (w_s1_is_call),
    .o_s1_is_ret   (w_s1_is_ret)
  );

  bim_counter_table #(
    .ENTRIES (ENTRIES)
  ) u_bim_counter_table (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_s0_pc      (w_s0_pc),
    .i_res_valid  (i_res_valid),
    .i_res_pc     (i_res_pc),
    .i_res_is_rvc (i_res_is_rvc),
    .i_res_taken  (i_res_taken),
    .o_s1_taken   (w_s1_taken)
  );

endmodule

/* src/fetch_pc_ctrl.sv */
// fetch fsm, search issue, predicted slot select and next pc
`timescale 1ns/1ns

module fetch_pc_ctrl
  import predict_pkg::*;
(
  input  logic                           i_clk,
  input  logic                           i_reset_n,

  input  logic                           i_start,
  input  logic [VADDR_W-1:0]             i_start_pc,
  input  logic                           i_stop,
  input  logic                           i_stall,
  input  logic                           i_redirect_valid,
  input  logic [VADDR_W-1:0]             i_redirect_pc,

  // s1 results from btb and counters
  input  logic [SLOT_N-1:0]              i_s1_hit,
  input  logic [SLOT_N-1:0]              i_s1_taken,
  input  logic [SLOT_N-1:0][VADDR_W-1:0] i_s1_target,
  input  logic [SLOT_N-1:0]              i_s1_is_call,
  input  logic [SLOT_N-1:0]              i_s1_is_ret,

  output logic                           o_s0_valid,
  output logic [VADDR_W-1:0]             o_s0_pc,

  output logic                           o_fetch_valid,
  output logic [VADDR_W-1:0]             o_fetch_pc,
  output logic                           o_pred_taken,
  output logic [SLOT_MSB-SLOT_LSB:0]     o_pred_slot,
  output logic                           o_pred_is_call,
  output logic                           o_pred_is_ret,
  output logic [VADDR_W-1:0]             o_next_pc
);

  localparam int SLOT_W = SLOT_MSB - SLOT_LSB + 1;

  fetch_state_t             r_state;
  logic [VADDR_W-1:0]       r_pc;

  logic                     w_load;
  logic [VADDR_W-1:0]       w_load_pc;
  logic                     w_kill;
  logic [SLOT_N-1:0]        w_sel;
  logic                     w_found;
  logic [SLOT_W-1:0]        w_slot;
  logic [VADDR_W-1:0]       w_seq_pc;

  // redirect wins over a start in the same cycle
  assign w_load    = i_redirect_valid | i_start;
  assign w_load_pc = i_redirect_valid ? i_redirect_pc : i_start_pc;
  assign w_kill    = w_load | i_stop;

  assign o_s0_valid    = (r_state == FS_ISSUE) & ~i_stall & ~w_kill;
  assign o_s0_pc       = r_pc;
  assign o_fetch_valid = (r_state == FS_RESOLVE) & ~w_kill;
  assign o_fetch_pc    = r_pc;

  // ----------------------------------------------------------------------
  // prediction, lowest hitting and taken slot
  // ----------------------------------------------------------------------
  assign w_sel = i_s1_hit & i_s1_taken;

  always_comb begin
    w_found = 1'b0;
    w_slot  = '0;
    for (int s = SLOT_N - 1; s >= 0; s--) begin
      if (w_sel[s]) begin
        w_found = 1'b1;
        w_slot  = SLOT_W'(s);
      end
    end
  end

  // block address plus one block
  assign w_seq_pc = (r_pc & ~VADDR_W'(2 * SLOT_N - 1)) + VADDR_W'(2 * SLOT_N);

  assign o_pred_taken   = w_found;
  assign o_pred_slot    = w_slot;
  assign o_pred_is_call = w_found & i_s1_is_call[w_slot];
  assign o_pred_is_ret  = w_found & i_s1_is_ret[w_slot];
  assign o_next_pc      = w_found ? i_s1_target[w_slot] : w_seq_pc;

  // ----------------------------------------------------------------------
  // fsm and pc register
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= FS_IDLE;
      r_pc    <= '0;
    end else if (i_redirect_valid) begin
      r_state <= FS_ISSUE;
      r_pc    <= w_load_pc;
    end else if (i_stop) begin
      r_state <= FS_IDLE;
    end else if (i_start) begin
      r_state <= FS_ISSUE;
      r_pc    <= w_load_pc;
    end else begin
      case (r_state)
        FS_ISSUE: begin
          // stall holds the search back
          if (!i_stall) begin
            r_state <= FS_RESOLVE;
          end
        end
        FS_RESOLVE: begin
          r_state <= FS_ISSUE;
          r_pc    <= o_next_pc;
        end
        default: r_state <= FS_IDLE;
      endcase
    end
  end

endmodule

/* src/bim_counter_table.sv */
// per-slot tables of 2-bit bimodal counters, trained on resolve
`timescale 1ns/1ns

module bim_counter_table
  import predict_pkg::*;
#(
  parameter int ENTRIES = BTB_ENTRY_SIZE
) (
  input  logic               i_clk,
  input  logic               i_reset_n,

  input  logic [VADDR_W-1:0] i_s0_pc,

  input  logic               i_res_valid,
  input  logic [VADDR_W-1:0] i_res_pc,
  input  logic               i_res_is_rvc,
  input  logic               i_res_taken,

  output logic [SLOT_N-1:0]  o_s1_taken
);

  localparam int IDX_W = $clog2(ENTRIES);

  // weakly not-taken
  localparam logic [1:0] CNT_INIT = 2'd1;

  logic [VADDR_W-1:0]       w_res_end;
  logic [SLOT_MSB:SLOT_LSB] w_res_slot;
  logic [IDX_W-1:0]         w_res_idx;
  logic [IDX_W-1:0]         w_s0_idx;

  assign w_res_end  = branch_end_addr(i_res_pc, i_res_is_rvc);
  assign w_res_slot = w_res_end[SLOT_MSB:SLOT_LSB];
  assign w_res_idx  = w_res_end[INDEX_LSB +: IDX_W];
  assign w_s0_idx   = i_s0_pc[INDEX_LSB +: IDX_W];

  for (genvar b = 0; b < SLOT_N; b++) begin : g_table
    logic       w_upd;
    logic [1:0] r_cnt [ENTRIES];

    assign w_upd = i_res_valid & (int'(w_res_slot) == b);

    // ------------------------------------------------------------------
    // saturating update, every resolve trains its entry
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        for (int e = 0; e < ENTRIES; e++) begin
          r_cnt[e] <= CNT_INIT;
        end
      end else if (w_upd) begin
        if (i_res_taken) begin
          if (r_cnt[w_res_idx] != 2'd3) begin
            r_cnt[w_res_idx] <= r_cnt[w_res_idx] + 2'd1;
          end
        end else if (r_cnt[w_res_idx] != 2'd0) begin
          r_cnt[w_res_idx] <= r_cnt[w_res_idx] - 2'd1;
        end
      end
    end

    // upper bit is the taken prediction
    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        o_s1_taken[b] <= 1'b0;
      end else begin
        o_s1_taken[b] <= r_cnt[w_s0_idx][1];
      end
    end
  end

endmodule

/* src/btb.sv */
// banked branch target buffer with valid flags, tag compare and slot mask
`timescale 1ns/1ns

module btb
  import predict_pkg::*;
#(
  parameter int ENTRIES = BTB_ENTRY_SIZE
) (
  input  logic                            i_clk,
  input  logic                            i_reset_n,

  // s0 search
  input  logic                            i_s0_valid,
  input  logic [VADDR_W-1:0]              i_s0_pc,

  // resolve update
  input  logic                            i_res_valid,
  input  logic [VADDR_W-1:0]              i_res_pc,
  input  logic                            i_res_is_rvc,
  input  logic                            i_res_taken,
  input  logic [VADDR_W-1:0]              i_res_target,
  input  logic                            i_res_is_call,
  input  logic                            i_res_is_ret,

  // s1 result, one bit or word per slot
  output logic [SLOT_N-1:0]               o_s1_hit,
  output logic [SLOT_N-1:0][VADDR_W-1:0]  o_s1_target,
  output logic [SLOT_N-1:0]               o_s1_is_call,
  output logic [SLOT_N-1:0]               o_s1_is_ret
);

  localparam int IDX_W = $clog2(ENTRIES);

  logic [VADDR_W-1:0]         w_res_end;
  logic [SLOT_MSB:SLOT_LSB]   w_res_slot;
  logic [IDX_W-1:0]           w_res_idx;
  logic [IDX_W-1:0]           w_s0_idx;
  logic [SLOT_MSB:SLOT_LSB]   w_s0_slot;
  logic [SLOT_N-1:0]          w_s0_mask;
  btb_entry_t                 w_wr_entry;

  logic                       r_s1_valid;
  logic [VADDR_W-1:TAG_LSB]   r_s1_tag;
  logic [SLOT_N-1:0]          r_s1_mask;

  // ----------------------------------------------------------------------
  // resolve side, end address picks bank and entry
  // ----------------------------------------------------------------------
  assign w_res_end  = branch_end_addr(i_res_pc, i_res_is_rvc);
  assign w_res_slot = w_res_end[SLOT_MSB:SLOT_LSB];
  assign w_res_idx  = w_res_end[INDEX_LSB +: IDX_W];

  assign w_wr_entry.is_call      = i_res_is_call;
  assign w_wr_entry.is_ret       = i_res_is_ret;
  assign w_wr_entry.pc_tag       = w_res_end[VADDR_W-1:TAG_LSB];
  assign w_wr_entry.target_vaddr = i_res_target;

  // ----------------------------------------------------------------------
  // search side
  // ----------------------------------------------------------------------
  assign w_s0_idx  = i_s0_pc[INDEX_LSB +: IDX_W];
  assign w_s0_slot = i_s0_pc[SLOT_MSB:SLOT_LSB];

  // slots before the pc offset are not part of this fetch
  always_comb begin
    for (int s = 0; s < SLOT_N; s++) begin
      w_s0_mask[s] = (s >= int'(w_s0_slot));
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s1_mask  <= '0;
    end else begin
      r_s1_valid <= i_s0_valid;
      r_s1_mask  <= w_s0_mask;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_tag <= i_s0_pc[VADDR_W-1:TAG_LSB];
  end

  for (genvar b = 0; b < SLOT_N; b++) begin : g_bank
    logic               w_wr;
    btb_entry_t         w_rd_entry;
    logic [ENTRIES-1:0] r_valids;
    logic               r_s1_entry_valid;

    assign w_wr = i_res_valid & i_res_taken & (int'(w_res_slot) == b);

    data_array_2p #(
      .WIDTH  ($bits(btb_entry_t)),
      .ADDR_W (IDX_W)
    ) u_array (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_wr      (w_wr),
      .i_wr_addr (w_res_idx),
      .i_wr_data (w_wr_entry),
      .i_rd_addr (w_s0_idx),
      .o_rd_data (w_rd_entry)
    );

    // valid flags sit beside the ram and are read with it
    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_valids         <= '0;
        r_s1_entry_valid <= 1'b0;
      end else begin
        if (w_wr) begin
          r_valids[w_res_idx] <= 1'b1;
        end
        r_s1_entry_valid <= r_valids[w_s0_idx];
      end
    end

    assign o_s1_hit[b]     = r_s1_valid & r_s1_entry_valid & r_s1_mask[b] &
                             (w_rd_entry.pc_tag == r_s1_tag);
    assign o_s1_target[b]  = w_rd_entry.target_vaddr;
    assign o_s1_is_call[b] = w_rd_entry.is_call;
    assign o_s1_is_ret[b]  = w_rd_entry.is_ret;
  end

endmodule

/* src/data_array_2p.sv */
// one-write one-read synchronous ram with registered read port
`timescale 1ns/1ns

module data_array_2p #(
  parameter int WIDTH  = 32,
  parameter int ADDR_W = 4
) (
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  logic              i_wr,
  input  logic [ADDR_W-1:0] i_wr_addr,
  input  logic [WIDTH-1:0]  i_wr_data,

  input  logic [ADDR_W-1:0] i_rd_addr,
  output logic [WIDTH-1:0]  o_rd_data
);

  logic [WIDTH-1:0] r_mem [2**ADDR_W];

  // array contents come up undefined
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_mem[i_wr_addr] <= i_wr_data;
    end
  end

  // read-during-write returns the old word
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_rd_data <= '0;
    end else begin
      o_rd_data <= r_mem[i_rd_addr];
    end
  end

endmodule

/* src/predict_pkg.sv */
// address widths, btb geometry, btb entry struct, fetch state enum, branch end address helper
package predict_pkg;

  // ----------------------------------------------------------------------
  // address and fetch block geometry
  // ----------------------------------------------------------------------
  localparam int VADDR_W = 32;

  // four 16-bit slots in an 8-byte fetch block, one btb bank per slot
  localparam int SLOT_N = 4;

  // default entries per bank
  localparam int BTB_ENTRY_SIZE = 16;

  // fields of the branch end-halfword address
  localparam int SLOT_LSB  = 1;
  localparam int SLOT_MSB  = 2;
  localparam int INDEX_LSB = 3;
  localparam int INDEX_MSB = 6;
  localparam int TAG_LSB   = INDEX_MSB + 1;

  // ----------------------------------------------------------------------
  // btb entry and fetch fsm state
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                       is_call;
    logic                       is_ret;
    logic [VADDR_W-TAG_LSB-1:0] pc_tag;
    logic [VADDR_W-1:0]         target_vaddr;
  } btb_entry_t;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_ISSUE,
    FS_RESOLVE
  } fetch_state_t;

  // address of the last halfword of a branch
  // a full-width branch ends one halfword after its pc
  function automatic logic [VADDR_W-1:0] branch_end_addr(
    input logic [VADDR_W-1:0] pc,
    input logic               is_rvc
  );
    branch_end_addr = pc + (is_rvc ? VADDR_W'(0) : VADDR_W'(2));
  endfunction

endpackage
